//--- design/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    // alu operations.
    localparam alu_op_t alu_add    = 4'd0;
    localparam alu_op_t alu_sub    = 4'd1;
    localparam alu_op_t alu_sll    = 4'd2;
    localparam alu_op_t alu_slt    = 4'd3;
    localparam alu_op_t alu_sltu   = 4'd4;
    localparam alu_op_t alu_xor    = 4'd5;
    localparam alu_op_t alu_srl    = 4'd6;
    localparam alu_op_t alu_sra    = 4'd7;
    localparam alu_op_t alu_or     = 4'd8;
    localparam alu_op_t alu_and    = 4'd9;
    localparam alu_op_t alu_pass_b = 4'd10;  // lui.

    // operand source in execute.
    localparam fwd_sel_t fwd_none = 2'd0;
    localparam fwd_sel_t fwd_mem  = 2'd1;
    localparam fwd_sel_t fwd_wb   = 2'd2;

    // rv32i major opcodes.
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam word_t nop_inst = 32'h0000_0013;  // addi x0, x0, 0.

endpackage

//--- design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic              cpu_clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              redirect,
    input  cpu_pkg::word_t    if_inst,
    input  cpu_pkg::word_t    if_pc,
    input  logic              if_valid,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::reg_idx_t id_rs1,
    output cpu_pkg::reg_idx_t id_rs2,
    output cpu_pkg::word_t    ex_pc,
    output cpu_pkg::word_t    ex_rs1_data,
    output cpu_pkg::word_t    ex_rs2_data,
    output cpu_pkg::word_t    ex_imm,
    output cpu_pkg::reg_idx_t ex_rs1,
    output cpu_pkg::reg_idx_t ex_rs2,
    output cpu_pkg::reg_idx_t ex_rd,
    output cpu_pkg::alu_op_t  ex_alu_op,
    output logic              ex_use_imm,
    output logic              ex_use_pc,
    output logic              ex_is_branch,
    output logic              ex_is_jal,
    output logic              ex_is_jalr,
    output logic              ex_is_load,
    output logic              ex_is_store,
    output logic              ex_reg_wen,
    output logic [2:0]        ex_funct3,
    output logic              ex_valid
);

    cpu_pkg::word_t   rs1_data, rs2_data, imm;
    cpu_pkg::word_t   i_imm, s_imm, b_imm, u_imm, j_imm;
    cpu_pkg::alu_op_t alu_op;
    logic             use_imm, use_pc, is_branch, is_jal, is_jalr;
    logic             is_load, is_store, reg_wen;

    function automatic cpu_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b001:  alu_sel = cpu_pkg::alu_sll;
            3'b010:  alu_sel = cpu_pkg::alu_slt;
            3'b011:  alu_sel = cpu_pkg::alu_sltu;
            3'b100:  alu_sel = cpu_pkg::alu_xor;
            3'b101:  alu_sel = alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            3'b110:  alu_sel = cpu_pkg::alu_or;
            default: alu_sel = cpu_pkg::alu_and;
        endcase
    endfunction

    assign id_rs1 = if_inst[19:15];
    assign id_rs2 = if_inst[24:20];

    assign i_imm = {{20{if_inst[31]}}, if_inst[31:20]};
    assign s_imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign b_imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                    if_inst[11:8], 1'b0};
    assign u_imm = {if_inst[31:12], 12'h000};
    assign j_imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
                    if_inst[30:21], 1'b0};

    always_comb begin
        alu_op    = cpu_pkg::alu_add;
        imm       = i_imm;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        reg_wen   = 1'b0;
        case (if_inst[6:0])
            cpu_pkg::op_lui: begin
                alu_op  = cpu_pkg::alu_pass_b;
                imm     = u_imm;
                use_imm = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_pkg::op_auipc: begin
                imm     = u_imm;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_pkg::op_jal: begin
                imm     = j_imm;
                is_jal  = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_pkg::op_jalr: begin
                is_jalr = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_pkg::op_branch: begin
                imm       = b_imm;
                is_branch = 1'b1;
            end
            cpu_pkg::op_load: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_pkg::op_store: begin
                imm      = s_imm;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            cpu_pkg::op_imm: begin
                // only srai uses bit 30 in immediate form.
                alu_op  = alu_sel(if_inst[14:12], if_inst[30] && if_inst[14:12] == 3'b101);
                use_imm = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_pkg::op_reg: begin
                alu_op  = alu_sel(if_inst[14:12], if_inst[30]);
                reg_wen = 1'b1;
            end
            default: ;
        endcase
    end

    reg_file u_regs (
        .cpu_clk  (cpu_clk),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_ff @(posedge cpu_clk) begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= if_valid && !stall && !redirect;  // bubble or flush.
    end

    always_ff @(posedge cpu_clk) begin
        ex_pc        <= if_pc;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_imm       <= imm;
        ex_rs1       <= id_rs1;
        ex_rs2       <= id_rs2;
        ex_rd        <= if_inst[11:7];
        ex_alu_op    <= alu_op;
        ex_use_imm   <= use_imm;
        ex_use_pc    <= use_pc;
        ex_is_branch <= is_branch;
        ex_is_jal    <= is_jal;
        ex_is_jalr   <= is_jalr;
        ex_is_load   <= is_load;
        ex_is_store  <= is_store;
        ex_reg_wen   <= reg_wen;
        ex_funct3    <= if_inst[14:12];
    end

endmodule

//--- design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic              cpu_clk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    ex_pc,
    input  cpu_pkg::word_t    ex_rs1_data,
    input  cpu_pkg::word_t    ex_rs2_data,
    input  cpu_pkg::word_t    ex_imm,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  cpu_pkg::alu_op_t  ex_alu_op,
    input  logic              ex_use_imm,
    input  logic              ex_use_pc,
    input  logic              ex_is_branch,
    input  logic              ex_is_jal,
    input  logic              ex_is_jalr,
    input  logic              ex_is_load,
    input  logic              ex_is_store,
    input  logic              ex_reg_wen,
    input  logic [2:0]        ex_funct3,
    input  logic              ex_valid,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::word_t    mem_result,
    input  cpu_pkg::word_t    wb_data,
    output logic              redirect,
    output cpu_pkg::word_t    redirect_pc,
    output cpu_pkg::word_t    mem_alu_result,
    output cpu_pkg::word_t    mem_store_data,
    output cpu_pkg::reg_idx_t mem_rd,
    output logic              mem_is_load,
    output logic              mem_is_store,
    output logic              mem_reg_wen,
    output cpu_pkg::word_t    mem_link,
    output logic              mem_is_link,
    output logic              mem_valid
);

    cpu_pkg::word_t rs1_val, rs2_val, op_a, op_b, alu_res;
    logic           take;

    function automatic cpu_pkg::word_t pick(input cpu_pkg::fwd_sel_t sel,
                                            input cpu_pkg::word_t    reg_val);
        case (sel)
            cpu_pkg::fwd_mem: pick = mem_result;
            cpu_pkg::fwd_wb:  pick = wb_data;
            default:          pick = reg_val;
        endcase
    endfunction

    always_comb begin
        rs1_val = pick(fwd_a, ex_rs1_data);
        rs2_val = pick(fwd_b, ex_rs2_data);
    end

    assign op_a    = ex_use_pc  ? ex_pc  : rs1_val;
    assign op_b    = ex_use_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::alu_sub:    alu_res = op_a - op_b;
            cpu_pkg::alu_sll:    alu_res = op_a << op_b[4:0];
            cpu_pkg::alu_slt:    alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_sltu:   alu_res = {31'h0, op_a < op_b};
            cpu_pkg::alu_xor:    alu_res = op_a ^ op_b;
            cpu_pkg::alu_srl:    alu_res = op_a >> op_b[4:0];
            cpu_pkg::alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
            cpu_pkg::alu_or:     alu_res = op_a | op_b;
            cpu_pkg::alu_and:    alu_res = op_a & op_b;
            cpu_pkg::alu_pass_b: alu_res = op_b;
            default:             alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ex_funct3)
            3'b000:  take = rs1_val == rs2_val;
            3'b001:  take = rs1_val != rs2_val;
            3'b100:  take = $signed(rs1_val) < $signed(rs2_val);
            3'b101:  take = $signed(rs1_val) >= $signed(rs2_val);
            3'b110:  take = rs1_val < rs2_val;
            3'b111:  take = rs1_val >= rs2_val;
            default: take = 1'b0;
        endcase
    end

    assign redirect    = ex_valid && ((ex_is_branch && take) || ex_is_jal || ex_is_jalr);
    assign redirect_pc = ex_is_jalr ? ((rs1_val + ex_imm) & ~32'h1) : ex_pc + ex_imm;

    always_ff @(posedge cpu_clk) begin
        if (!rst_n)
            mem_valid <= 1'b0;
        else
            mem_valid <= ex_valid;
    end

    always_ff @(posedge cpu_clk) begin
        mem_alu_result <= alu_res;
        mem_store_data <= rs2_val;
        mem_rd         <= ex_rd;
        mem_is_load    <= ex_is_load;
        mem_is_store   <= ex_is_store;
        mem_reg_wen    <= ex_reg_wen;
        mem_link       <= ex_pc + 32'd4;  // return address.
        mem_is_link    <= ex_is_jal || ex_is_jalr;
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0
) (
    input  logic           cpu_clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t irom_data,
    output cpu_pkg::word_t irom_addr,
    output cpu_pkg::word_t if_inst,
    output cpu_pkg::word_t if_pc,
    output logic           if_valid
);

    cpu_pkg::word_t pc;

    assign irom_addr = pc;

    always_ff @(posedge cpu_clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            if_valid <= 1'b0;  // wrong-path fetch dropped.
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (redirect) begin
            if_inst <= cpu_pkg::nop_inst;
        end else if (!stall) begin
            if_inst <= irom_data;
            if_pc   <= pc;
        end
    end

endmodule

//--- design/hazard_control.sv
`timescale 1ns/1ps

module hazard_control (
    input  cpu_pkg::reg_idx_t id_rs1,
    input  cpu_pkg::reg_idx_t id_rs2,
    input  cpu_pkg::reg_idx_t ex_rs1,
    input  cpu_pkg::reg_idx_t ex_rs2,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  logic              ex_is_load,
    input  logic              ex_valid,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  logic              mem_reg_wen,
    input  logic              mem_valid,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  logic              wb_en,
    output logic              stall,
    output cpu_pkg::fwd_sel_t fwd_a,
    output cpu_pkg::fwd_sel_t fwd_b
);

    // youngest producer wins.
    function automatic cpu_pkg::fwd_sel_t src(input cpu_pkg::reg_idx_t rs);
        if (rs == 5'd0)
            src = cpu_pkg::fwd_none;
        else if (mem_valid && mem_reg_wen && mem_rd == rs)
            src = cpu_pkg::fwd_mem;
        else if (wb_en && wb_rd == rs)
            src = cpu_pkg::fwd_wb;
        else
            src = cpu_pkg::fwd_none;
    endfunction

    // load data is not ready until write-back.
    assign stall = ex_valid && ex_is_load && ex_rd != 5'd0 &&
                   (ex_rd == id_rs1 || ex_rd == id_rs2);

    always_comb begin
        fwd_a = src(ex_rs1);
        fwd_b = src(ex_rs2);
    end

endmodule

//--- design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              cpu_clk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    mem_alu_result,
    input  cpu_pkg::word_t    mem_store_data,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  logic              mem_is_load,
    input  logic              mem_is_store,
    input  logic              mem_reg_wen,
    input  cpu_pkg::word_t    mem_link,
    input  logic              mem_is_link,
    input  logic              mem_valid,
    input  cpu_pkg::word_t    perip_rdata,
    output cpu_pkg::word_t    perip_addr,
    output logic              perip_wen,
    output cpu_pkg::word_t    perip_wdata,
    output cpu_pkg::word_t    mem_result,
    output logic              wb_en,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_data
);

    assign perip_addr  = mem_alu_result;
    assign perip_wdata = mem_store_data;
    assign perip_wen   = mem_valid && mem_is_store;

    // forwarded value is never a load.
    assign mem_result = mem_is_link ? mem_link : mem_alu_result;

    always_ff @(posedge cpu_clk) begin
        if (!rst_n)
            wb_en <= 1'b0;
        else
            wb_en <= mem_valid && mem_reg_wen;
    end

    always_ff @(posedge cpu_clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_is_load ? perip_rdata : mem_result;
    end

endmodule

//--- design/my_cpu.sv
`timescale 1ns/1ps

module my_cpu #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0
) (
    input  logic           cpu_clk,
    input  logic           rst_n,
    output cpu_pkg::word_t irom_addr,
    input  cpu_pkg::word_t irom_data,
    output cpu_pkg::word_t perip_addr,
    output logic           perip_wen,
    output cpu_pkg::word_t perip_wdata,
    input  cpu_pkg::word_t perip_rdata
);

    logic              stall, redirect;
    cpu_pkg::word_t    redirect_pc;
    cpu_pkg::word_t    if_inst, if_pc;
    logic              if_valid;
    cpu_pkg::reg_idx_t id_rs1, id_rs2;
    cpu_pkg::word_t    ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    cpu_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd;
    cpu_pkg::alu_op_t  ex_alu_op;
    logic              ex_use_imm, ex_use_pc, ex_is_branch, ex_is_jal, ex_is_jalr;
    logic              ex_is_load, ex_is_store, ex_reg_wen, ex_valid;
    logic [2:0]        ex_funct3;
    cpu_pkg::fwd_sel_t fwd_a, fwd_b;
    cpu_pkg::word_t    mem_alu_result, mem_store_data, mem_link, mem_result;
    cpu_pkg::reg_idx_t mem_rd;
    logic              mem_is_load, mem_is_store, mem_reg_wen, mem_is_link, mem_valid;
    logic              wb_en;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .cpu_clk     (cpu_clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .irom_data   (irom_data),
        .irom_addr   (irom_addr),
        .if_inst     (if_inst),
        .if_pc       (if_pc),
        .if_valid    (if_valid)
    );

    decode_unit u_decode (
        .cpu_clk      (cpu_clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .redirect     (redirect),
        .if_inst      (if_inst),
        .if_pc        (if_pc),
        .if_valid     (if_valid),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .ex_pc        (ex_pc),
        .ex_rs1_data  (ex_rs1_data),
        .ex_rs2_data  (ex_rs2_data),
        .ex_imm       (ex_imm),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_rd        (ex_rd),
        .ex_alu_op    (ex_alu_op),
        .ex_use_imm   (ex_use_imm),
        .ex_use_pc    (ex_use_pc),
        .ex_is_branch (ex_is_branch),
        .ex_is_jal    (ex_is_jal),
        .ex_is_jalr   (ex_is_jalr),
        .ex_is_load   (ex_is_load),
        .ex_is_store  (ex_is_store),
        .ex_reg_wen   (ex_reg_wen),
        .ex_funct3    (ex_funct3),
        .ex_valid     (ex_valid)
    );

    execute_unit u_execute (
        .cpu_clk        (cpu_clk),
        .rst_n          (rst_n),
        .ex_pc          (ex_pc),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_imm         (ex_imm),
        .ex_rd          (ex_rd),
        .ex_alu_op      (ex_alu_op),
        .ex_use_imm     (ex_use_imm),
        .ex_use_pc      (ex_use_pc),
        .ex_is_branch   (ex_is_branch),
        .ex_is_jal      (ex_is_jal),
        .ex_is_jalr     (ex_is_jalr),
        .ex_is_load     (ex_is_load),
        .ex_is_store    (ex_is_store),
        .ex_reg_wen     (ex_reg_wen),
        .ex_funct3      (ex_funct3),
        .ex_valid       (ex_valid),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .mem_result     (mem_result),
        .wb_data        (wb_data),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_rd         (mem_rd),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_reg_wen    (mem_reg_wen),
        .mem_link       (mem_link),
        .mem_is_link    (mem_is_link),
        .mem_valid      (mem_valid)
    );

    mem_wb_stage u_mem_wb (
        .cpu_clk        (cpu_clk),
        .rst_n          (rst_n),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_rd         (mem_rd),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_reg_wen    (mem_reg_wen),
        .mem_link       (mem_link),
        .mem_is_link    (mem_is_link),
        .mem_valid      (mem_valid),
        .perip_rdata    (perip_rdata),
        .perip_addr     (perip_addr),
        .perip_wen      (perip_wen),
        .perip_wdata    (perip_wdata),
        .mem_result     (mem_result),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    hazard_control u_hazard (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rd       (ex_rd),
        .ex_is_load  (ex_is_load),
        .ex_valid    (ex_valid),
        .mem_rd      (mem_rd),
        .mem_reg_wen (mem_reg_wen),
        .mem_valid   (mem_valid),
        .wb_rd       (wb_rd),
        .wb_en       (wb_en),
        .stall       (stall),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              cpu_clk,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::word_t    rs1_data,
    output cpu_pkg::word_t    rs2_data
);

    cpu_pkg::word_t regs [1:31];  // x0 is not stored.

    always_ff @(posedge cpu_clk) begin
        if (wb_en && wb_rd != 5'd0)
            regs[wb_rd] <= wb_data;
    end

    // same-cycle write bypasses the array.
    assign rs1_data = (rs1 == 5'd0)                ? 32'h0   :
                      (wb_en && wb_rd == rs1)       ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0)                ? 32'h0   :
                      (wb_en && wb_rd == rs2)       ? wb_data : regs[rs2];

endmodule

//--- filelist.f
design/cpu_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/hazard_control.sv
design/mem_wb_stage.sv
design/my_cpu.sv
verif/tb_my_cpu.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then search the log for the failure line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_my_cpu -f filelist.f > sim.log 2>&1 &&
    ./obj_dir/Vtb_my_cpu >> sim.log 2>&1 ||
    echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && echo "simulation failed" && exit 1
echo "simulation passed"
exit 0

//--- verif/tb_my_cpu.sv
`timescale 1ns/1ps

module tb_my_cpu;

    localparam int rom_words     = 64;
    localparam int ram_words     = 64;
    localparam int prog_len      = 12;
    localparam int num_rows      = 5;
    localparam int reset_cycles  = 8;
    localparam int store_timeout = 200;
    localparam int quiet_cycles  = 16;

    localparam logic [31:0] op_lui   = 32'h37;
    localparam logic [31:0] op_auipc = 32'h17;
    localparam logic [31:0] op_jalr  = 32'h67;
    localparam logic [31:0] op_load  = 32'h03;
    localparam logic [31:0] op_imm   = 32'h13;

    logic        clk;
    logic        rst_n;
    logic [31:0] irom_addr, irom_data;
    logic [31:0] perip_addr, perip_wdata, perip_rdata;
    logic        perip_wen;

    logic [31:0] rom [rom_words];
    logic [31:0] ram [ram_words];

    logic [31:0] prog_tab [num_rows][prog_len];
    logic [31:0] exp_addr [num_rows];
    logic [31:0] exp_data [num_rows];  // addend when the row loads.
    int          ram_idx  [num_rows];  // -1 for no load.

    my_cpu #(.RESET_PC(32'h0)) uut (
        .cpu_clk     (clk),
        .rst_n       (rst_n),
        .irom_addr   (irom_addr),
        .irom_data   (irom_data),
        .perip_addr  (perip_addr),
        .perip_wen   (perip_wen),
        .perip_wdata (perip_wdata),
        .perip_rdata (perip_rdata)
    );

    // both memories answer in the same cycle.
    assign irom_data   = rom[irom_addr[7:2]];
    assign perip_rdata = ram[perip_addr[7:2]];

    always @(posedge clk) begin
        if (perip_wen)
            ram[perip_addr[7:2]] = perip_wdata;
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [31:0] f7, f3, rd, rs1, rs2);
        r_type = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] op, f3, rd, rs1, imm);
        i_type = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] rs2, rs1, imm);
        s_type = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] f3, rs1, rs2, imm);
        b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                  7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [31:0] op, rd, imm20);
        u_type = {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] rd, imm);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // addi x0, x0, index.
    function automatic logic [31:0] rom_fill(input int idx);
        rom_fill = i_type(op_imm, 0, 0, 0, idx);
    endfunction

    task automatic build_table();
        int r;
        int k;
        for (r = 0; r < num_rows; r++) begin
            for (k = 0; k < prog_len; k++)
                prog_tab[r][k] = rom_fill(k);
            ram_idx[r] = -1;
        end
        // alu chain where each step uses the one before.
        prog_tab[0][0] = i_type(op_imm, 0, 1, 0, 32'h123);
        prog_tab[0][1] = r_type(0, 0, 2, 1, 1);
        prog_tab[0][2] = r_type(32'h20, 0, 3, 1, 2);
        prog_tab[0][3] = r_type(0, 4, 4, 3, 2);
        prog_tab[0][4] = r_type(0, 1, 5, 4, 1);
        prog_tab[0][5] = r_type(32'h20, 5, 6, 5, 2);
        prog_tab[0][6] = s_type(6, 0, 32'h40);
        prog_tab[0][7] = j_type(0, 0);
        exp_addr[0] = 32'h40;
        exp_data[0] = 32'hffff_ff93;
        // lui plus auipc at pc 4.
        prog_tab[1][0] = u_type(op_lui, 1, 32'h12345);
        prog_tab[1][1] = u_type(op_auipc, 2, 32'h10);
        prog_tab[1][2] = r_type(0, 0, 3, 1, 2);
        prog_tab[1][3] = s_type(3, 0, 32'h44);
        prog_tab[1][4] = j_type(0, 0);
        exp_addr[1] = 32'h44;
        exp_data[1] = 32'h1235_5004;
        // load used at once.
        prog_tab[2][0] = i_type(op_load, 2, 1, 0, 32'h20);
        prog_tab[2][1] = i_type(op_imm, 0, 2, 1, 32'h55);
        prog_tab[2][2] = s_type(2, 0, 32'h48);
        prog_tab[2][3] = j_type(0, 0);
        exp_addr[2] = 32'h48;
        exp_data[2] = 32'h55;
        ram_idx[2]  = 8;
        // taken beq over a wrong store and a bne that falls through.
        prog_tab[3][0] = i_type(op_imm, 0, 1, 0, 7);
        prog_tab[3][1] = i_type(op_imm, 0, 2, 0, 7);
        prog_tab[3][2] = b_type(0, 1, 2, 12);
        prog_tab[3][3] = i_type(op_imm, 0, 3, 0, 32'h7ad);
        prog_tab[3][4] = s_type(3, 0, 32'h4c);
        prog_tab[3][5] = b_type(1, 1, 2, 12);
        prog_tab[3][6] = i_type(op_imm, 0, 4, 0, 32'h5a5);
        prog_tab[3][7] = s_type(4, 0, 32'h4c);
        prog_tab[3][8] = j_type(0, 0);
        exp_addr[3] = 32'h4c;
        exp_data[3] = 32'h5a5;
        // jal links 4 and jalr links 12.
        prog_tab[4][0] = j_type(1, 8);
        prog_tab[4][1] = s_type(0, 0, 32'h50);
        prog_tab[4][2] = i_type(op_jalr, 0, 2, 1, 12);
        prog_tab[4][3] = s_type(0, 0, 32'h50);
        prog_tab[4][4] = i_type(op_imm, 1, 3, 1, 8);
        prog_tab[4][5] = r_type(0, 6, 4, 3, 2);
        prog_tab[4][6] = s_type(4, 0, 32'h50);
        prog_tab[4][7] = j_type(0, 0);
        exp_addr[4] = 32'h50;
        exp_data[4] = 32'h40c;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, want);
        assert (got === want)
            else fail_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, want));
    endtask

    task automatic wait_store(input int row);
        int cycles;
        cycles = 0;
        while (perip_wen !== 1'b1 && cycles < store_timeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (perip_wen === 1'b1)
            else fail_run($sformatf("row %0d: no store arrived within %0d cycles",
                                    row, store_timeout));
    endtask

    task automatic run_row(input int row);
        logic [31:0] expected;
        int i;
        @(posedge clk);
        rst_n <= 1'b0;
        for (i = 0; i < rom_words; i++)
            rom[i] = (i < prog_len) ? prog_tab[row][i] : rom_fill(i);
        for (i = 0; i < ram_words; i++)
            ram[i] = $urandom;
        expected = exp_data[row];
        if (ram_idx[row] >= 0)
            expected = ram[ram_idx[row]] + exp_data[row];
        repeat (reset_cycles - 1) begin
            @(posedge clk);
            @(negedge clk);
            assert (perip_wen === 1'b0) else fail_run("perip_wen went high during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (perip_wen === 1'b0) else fail_run("perip_wen went high during reset");
        check_word("irom_addr", irom_addr, 32'h0);
        wait_store(row);
        check_word("perip_addr", perip_addr, exp_addr[row]);
        check_word("perip_wdata", perip_wdata, expected);
        repeat (quiet_cycles) begin
            @(negedge clk);
            assert (perip_wen === 1'b0)
                else fail_run($sformatf("row %0d: a second store appeared", row));
        end
    endtask

    initial begin
        int i;
        int row;
        rst_n = 1'b0;
        void'($urandom(32'hfbc3_216d));
        for (i = 0; i < rom_words; i++)
            rom[i] = rom_fill(i);
        for (i = 0; i < ram_words; i++)
            ram[i] = 32'h0;
        build_table();
        for (row = 0; row < num_rows; row++)
            run_row(row);
        $display("Test OK");
        $finish;
    end

endmodule
